// File: design/dll_pkg.sv
package dll_pkg;

    //////////////////////////////////////////////////
    // list sizes
    //////////////////////////////////////////////////

    localparam int MAX_NODE   = 8;
    localparam int DATA_WIDTH = 8;
    // one spare code above the last slot serves as null
    localparam int ADDR_WIDTH = 4;
    localparam int SLOT_WIDTH = $clog2(MAX_NODE);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    localparam addr_t ADDR_NULL = addr_t'(MAX_NODE);

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_READ_INDEX   = 3'd0,
        OP_DELETE_VALUE = 3'd2,
        OP_INSERT_INDEX = 3'd5,
        OP_DELETE_INDEX = 3'd7
    } op_t;

    // controller FSM states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_WALK      = 3'd1,
        ST_MATCH     = 3'd2,
        ST_SPLICE    = 3'd3,
        ST_DONE      = 3'd4,
        ST_FAULT_OUT = 3'd5
    } ctrl_state_t;

endpackage

// File: design/dll_top.sv
`timescale 1ns/100ps

module dll_top (
    input  logic            clk,
    input  logic            rst,
    input  dll_pkg::op_t    op,
    input  logic            op_start,
    input  dll_pkg::data_t  data_in,
    input  dll_pkg::addr_t  index_in,
    output logic            op_done,
    output logic            fault,
    output dll_pkg::data_t  data_out,
    output dll_pkg::addr_t  length,
    output logic            full,
    output logic            empty
);
    import dll_pkg::*;

    // read port
    logic                rd_en;
    addr_t               rd_addr;
    data_t               rd_data;
    addr_t               rd_next;
    addr_t               rd_prev;
    logic                rd_valid;

    // write ports
    logic                dat_wr_en;
    addr_t               dat_wr_addr;
    data_t               dat_wr_data;
    logic                dat_wr_valid;
    logic                nxt_wr_en;
    addr_t               nxt_wr_addr;
    addr_t               nxt_wr_data;
    logic                prv_wr_en;
    addr_t               prv_wr_addr;
    addr_t               prv_wr_data;

    // slot occupancy
    logic [MAX_NODE-1:0] valid_bits;
    addr_t               free_addr;

    list_control list_control_i (
        .clk          (clk),
        .rst          (rst),
        .op           (op),
        .op_start     (op_start),
        .data_in      (data_in),
        .index_in     (index_in),
        .rd_data      (rd_data),
        .rd_next      (rd_next),
        .rd_prev      (rd_prev),
        .rd_valid     (rd_valid),
        .free_addr    (free_addr),
        .full         (full),
        .empty        (empty),
        .op_done      (op_done),
        .fault        (fault),
        .data_out     (data_out),
        .length       (length),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .dat_wr_en    (dat_wr_en),
        .dat_wr_addr  (dat_wr_addr),
        .dat_wr_data  (dat_wr_data),
        .dat_wr_valid (dat_wr_valid),
        .nxt_wr_en    (nxt_wr_en),
        .nxt_wr_addr  (nxt_wr_addr),
        .nxt_wr_data  (nxt_wr_data),
        .prv_wr_en    (prv_wr_en),
        .prv_wr_addr  (prv_wr_addr),
        .prv_wr_data  (prv_wr_data)
    );

    node_store node_store_i (
        .clk          (clk),
        .rst          (rst),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .dat_wr_en    (dat_wr_en),
        .dat_wr_addr  (dat_wr_addr),
        .dat_wr_data  (dat_wr_data),
        .dat_wr_valid (dat_wr_valid),
        .nxt_wr_en    (nxt_wr_en),
        .nxt_wr_addr  (nxt_wr_addr),
        .nxt_wr_data  (nxt_wr_data),
        .prv_wr_en    (prv_wr_en),
        .prv_wr_addr  (prv_wr_addr),
        .prv_wr_data  (prv_wr_data),
        .rd_data      (rd_data),
        .rd_next      (rd_next),
        .rd_prev      (rd_prev),
        .rd_valid     (rd_valid),
        .valid_bits   (valid_bits)
    );

    free_slot_finder free_slot_finder_i (
        .valid_bits (valid_bits),
        .free_addr  (free_addr),
        .full       (full),
        .empty      (empty)
    );

endmodule

// File: design/free_slot_finder.sv
`timescale 1ns/100ps

module free_slot_finder (
    input  logic [dll_pkg::MAX_NODE-1:0] valid_bits,
    output dll_pkg::addr_t               free_addr,
    output logic                         full,
    output logic                         empty
);
    import dll_pkg::*;

    // lowest free slot wins, null when all are taken
    always_comb begin
        free_addr = ADDR_NULL;
        for (int i = MAX_NODE - 1; i >= 0; i--) begin
            if (!valid_bits[i]) begin
                free_addr = addr_t'(i);
            end
        end
    end

    assign full  = &valid_bits;
    assign empty = ~|valid_bits;

endmodule

// File: design/list_control.sv
`timescale 1ns/100ps

module list_control (
    input  logic           clk,
    input  logic           rst,
    input  dll_pkg::op_t   op,
    input  logic           op_start,
    input  dll_pkg::data_t data_in,
    input  dll_pkg::addr_t index_in,
    input  dll_pkg::data_t rd_data,
    input  dll_pkg::addr_t rd_next,
    input  dll_pkg::addr_t rd_prev,
    input  logic           rd_valid,
    input  dll_pkg::addr_t free_addr,
    input  logic           full,
    input  logic           empty,
    output logic           op_done,
    output logic           fault,
    output dll_pkg::data_t data_out,
    output dll_pkg::addr_t length,
    output logic           rd_en,
    output dll_pkg::addr_t rd_addr,
    output logic           dat_wr_en,
    output dll_pkg::addr_t dat_wr_addr,
    output dll_pkg::data_t dat_wr_data,
    output logic           dat_wr_valid,
    output logic           nxt_wr_en,
    output dll_pkg::addr_t nxt_wr_addr,
    output dll_pkg::addr_t nxt_wr_data,
    output logic           prv_wr_en,
    output dll_pkg::addr_t prv_wr_addr,
    output dll_pkg::addr_t prv_wr_data
);
    import dll_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    addr_t       head_q;
    addr_t       tail_q;
    addr_t       pos_q;
    addr_t       cur_ptr_q;
    addr_t       ins_addr_q;
    addr_t       last_pos;
    logic        walk_hit;

    assign last_pos = length - addr_t'(1);

    // delete by value compares data, the index ops compare position
    assign walk_hit = (op == OP_DELETE_VALUE) ? (rd_data == data_in) : (pos_q == index_in);

    //////////////////////////////////////////////////
    // next state and store access
    //////////////////////////////////////////////////

    always_comb begin
        state_d      = state_q;
        rd_en        = 1'b0;
        rd_addr      = head_q;
        dat_wr_en    = 1'b0;
        dat_wr_addr  = free_addr;
        dat_wr_data  = data_in;
        dat_wr_valid = 1'b1;
        nxt_wr_en    = 1'b0;
        nxt_wr_addr  = cur_ptr_q;
        nxt_wr_data  = ADDR_NULL;
        prv_wr_en    = 1'b0;
        prv_wr_addr  = cur_ptr_q;
        prv_wr_data  = ADDR_NULL;

        case (state_q)
            ST_IDLE: begin
                if (op_start) begin
                    case (op)
                        OP_INSERT_INDEX: begin
                            if (full) begin
                                state_d = ST_FAULT_OUT;
                            end else if (empty || index_in == '0) begin
                                // new head, old head points back to it
                                dat_wr_en   = 1'b1;
                                nxt_wr_en   = 1'b1;
                                nxt_wr_addr = free_addr;
                                nxt_wr_data = head_q;
                                prv_wr_en   = !empty;
                                prv_wr_addr = head_q;
                                prv_wr_data = free_addr;
                                state_d     = ST_DONE;
                            end else if (index_in >= length) begin
                                // append behind the tail
                                dat_wr_en   = 1'b1;
                                nxt_wr_en   = 1'b1;
                                nxt_wr_addr = tail_q;
                                nxt_wr_data = free_addr;
                                prv_wr_en   = 1'b1;
                                prv_wr_addr = free_addr;
                                prv_wr_data = tail_q;
                                state_d     = ST_DONE;
                            end else begin
                                rd_en   = 1'b1;
                                state_d = ST_WALK;
                            end
                        end
                        OP_READ_INDEX, OP_DELETE_INDEX: begin
                            if (empty || index_in >= length) begin
                                state_d = ST_FAULT_OUT;
                            end else begin
                                rd_en   = 1'b1;
                                state_d = ST_WALK;
                            end
                        end
                        OP_DELETE_VALUE: begin
                            if (empty) begin
                                state_d = ST_FAULT_OUT;
                            end else begin
                                rd_en   = 1'b1;
                                state_d = ST_WALK;
                            end
                        end
                        default: begin
                            state_d = ST_FAULT_OUT;
                        end
                    endcase
                end
            end
            ST_WALK: begin
                if (!rd_valid) begin
                    state_d = ST_FAULT_OUT;
                end else if (walk_hit) begin
                    state_d = ST_MATCH;
                end else if (pos_q == last_pos) begin
                    // ran off the tail without a match
                    state_d = ST_FAULT_OUT;
                end else begin
                    rd_en   = 1'b1;
                    rd_addr = rd_next;
                end
            end
            ST_MATCH: begin
                case (op)
                    OP_READ_INDEX: begin
                        state_d = ST_DONE;
                    end
                    OP_INSERT_INDEX: begin
                        // new node behind the predecessor of the hit node
                        dat_wr_en   = 1'b1;
                        dat_wr_addr = ins_addr_q;
                        prv_wr_en   = 1'b1;
                        prv_wr_addr = ins_addr_q;
                        prv_wr_data = rd_prev;
                        nxt_wr_en   = 1'b1;
                        nxt_wr_addr = rd_prev;
                        nxt_wr_data = ins_addr_q;
                        state_d     = ST_SPLICE;
                    end
                    default: begin
                        // unlink, end links of the list are never followed
                        dat_wr_en    = 1'b1;
                        dat_wr_addr  = cur_ptr_q;
                        dat_wr_valid = 1'b0;
                        nxt_wr_en    = (cur_ptr_q != head_q);
                        nxt_wr_addr  = rd_prev;
                        nxt_wr_data  = rd_next;
                        prv_wr_en    = (cur_ptr_q != tail_q);
                        prv_wr_addr  = rd_next;
                        prv_wr_data  = rd_prev;
                        state_d      = ST_DONE;
                    end
                endcase
            end
            ST_SPLICE: begin
                nxt_wr_en   = 1'b1;
                nxt_wr_addr = ins_addr_q;
                nxt_wr_data = cur_ptr_q;
                prv_wr_en   = 1'b1;
                prv_wr_addr = cur_ptr_q;
                prv_wr_data = ins_addr_q;
                state_d     = ST_DONE;
            end
            ST_DONE, ST_FAULT_OUT: begin
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    //////////////////////////////////////////////////
    // walk registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_IDLE;
            pos_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_IDLE) begin
                pos_q <= '0;
            end else if (rd_en) begin
                pos_q <= pos_q + addr_t'(1);
            end
        end
    end

    // slot under the read buffer, and the slot picked for an insert
    always_ff @(posedge clk) begin
        if (rd_en) begin
            cur_ptr_q <= rd_addr;
        end
        if (state_q == ST_IDLE) begin
            ins_addr_q <= free_addr;
        end
    end

    //////////////////////////////////////////////////
    // list state and outputs
    //////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q   <= ADDR_NULL;
            tail_q   <= ADDR_NULL;
            length   <= '0;
            data_out <= '0;
            op_done  <= 1'b0;
            fault    <= 1'b0;
        end else begin
            op_done <= (state_q == ST_DONE) || (state_q == ST_FAULT_OUT);
            fault   <= (state_q == ST_FAULT_OUT);
            if (state_q == ST_MATCH && op == OP_READ_INDEX) begin
                data_out <= rd_data;
            end
            if (state_q == ST_DONE) begin
                case (op)
                    OP_INSERT_INDEX: begin
                        length <= length + addr_t'(1);
                        if (length == '0 || index_in == '0) begin
                            head_q <= ins_addr_q;
                        end
                        if (length == '0 || index_in >= length) begin
                            tail_q <= ins_addr_q;
                        end
                    end
                    OP_DELETE_INDEX, OP_DELETE_VALUE: begin
                        length <= last_pos;
                        if (length == addr_t'(1)) begin
                            head_q <= ADDR_NULL;
                            tail_q <= ADDR_NULL;
                        end else begin
                            if (cur_ptr_q == head_q) begin
                                head_q <= rd_next;
                            end
                            if (cur_ptr_q == tail_q) begin
                                tail_q <= rd_prev;
                            end
                        end
                    end
                    default: begin
                        length <= length;
                    end
                endcase
            end
        end
    end

endmodule

// File: design/node_store.sv
`timescale 1ns/100ps

module node_store (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_en,
    input  dll_pkg::addr_t           rd_addr,
    input  logic                     dat_wr_en,
    input  dll_pkg::addr_t           dat_wr_addr,
    input  dll_pkg::data_t           dat_wr_data,
    input  logic                     dat_wr_valid,
    input  logic                     nxt_wr_en,
    input  dll_pkg::addr_t           nxt_wr_addr,
    input  dll_pkg::addr_t           nxt_wr_data,
    input  logic                     prv_wr_en,
    input  dll_pkg::addr_t           prv_wr_addr,
    input  dll_pkg::addr_t           prv_wr_data,
    output dll_pkg::data_t           rd_data,
    output dll_pkg::addr_t           rd_next,
    output dll_pkg::addr_t           rd_prev,
    output logic                     rd_valid,
    output logic [dll_pkg::MAX_NODE-1:0] valid_bits
);
    import dll_pkg::*;

    data_t                 data_mem [MAX_NODE];
    addr_t                 next_mem [MAX_NODE];
    addr_t                 prev_mem [MAX_NODE];
    logic [MAX_NODE-1:0]   valid_q;

    // slot select, the null code is never used as a write address
    logic [SLOT_WIDTH-1:0] rd_slot;
    logic [SLOT_WIDTH-1:0] dat_slot;
    logic [SLOT_WIDTH-1:0] nxt_slot;
    logic [SLOT_WIDTH-1:0] prv_slot;

    assign rd_slot  = rd_addr[SLOT_WIDTH-1:0];
    assign dat_slot = dat_wr_addr[SLOT_WIDTH-1:0];
    assign nxt_slot = nxt_wr_addr[SLOT_WIDTH-1:0];
    assign prv_slot = prv_wr_addr[SLOT_WIDTH-1:0];

    always_ff @(posedge clk) begin
        if (dat_wr_en) begin
            data_mem[dat_slot] <= dat_wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (dat_wr_en) begin
            valid_q[dat_slot] <= dat_wr_valid;
        end
    end

    // link arrays start out unlinked
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MAX_NODE; i++) begin
                next_mem[i] <= ADDR_NULL;
                prev_mem[i] <= ADDR_NULL;
            end
        end else begin
            if (nxt_wr_en) begin
                next_mem[nxt_slot] <= nxt_wr_data;
            end
            if (prv_wr_en) begin
                prev_mem[prv_slot] <= prv_wr_data;
            end
        end
    end

    // read buffer for the walk
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data  <= data_mem[rd_slot];
            rd_next  <= next_mem[rd_slot];
            rd_prev  <= prev_mem[rd_slot];
            rd_valid <= valid_q[rd_slot];
        end
    end

    assign valid_bits = valid_q;

endmodule

// File: dll.f
design/dll_pkg.sv
design/free_slot_finder.sv
design/node_store.sv
design/list_control.sv
design/dll_top.sv
testbench/tb_clock.sv
testbench/dll_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --top-module dll_tb -f dll.f -o dll_sim

./obj_dir/dll_sim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: testbench/dll_tb.sv
`timescale 1ns/100ps

module dll_tb;
    import dll_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RESET_CYCLES   = 16;

    logic  clk;
    logic  rst;
    op_t   op;
    logic  op_start;
    data_t data_in;
    addr_t index_in;
    logic  op_done;
    logic  fault;
    data_t data_out;
    addr_t length;
    logic  full;
    logic  empty;

    // operation table, one column per queue
    logic [2:0] tab_op    [$];
    data_t      tab_data  [$];
    addr_t      tab_index [$];
    logic       tab_fault [$];
    data_t      tab_dout  [$];
    addr_t      tab_len   [$];

    int   error_count;
    int   entries_run;
    int   entries_failed;
    int   n;
    logic timed_out;

    tb_clock tb_clock_i (
        .clk (clk)
    );

    dll_top dll_top_i (
        .clk      (clk),
        .rst      (rst),
        .op       (op),
        .op_start (op_start),
        .data_in  (data_in),
        .index_in (index_in),
        .op_done  (op_done),
        .fault    (fault),
        .data_out (data_out),
        .length   (length),
        .full     (full),
        .empty    (empty)
    );

    task automatic add_entry(input logic [2:0] e_op, input data_t e_data, input addr_t e_index,
                             input logic e_fault, input data_t e_dout, input addr_t e_len);
        tab_op.push_back(e_op);
        tab_data.push_back(e_data);
        tab_index.push_back(e_index);
        tab_fault.push_back(e_fault);
        tab_dout.push_back(e_dout);
        tab_len.push_back(e_len);
    endtask

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    //////////////////////////////////////////////////
    // expected list contents noted after each step
    //////////////////////////////////////////////////

    task automatic build_table;
        // empty list, everything faults
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b1, 8'h00, 4'd0);
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd0, 1'b1, 8'h00, 4'd0);
        add_entry(OP_DELETE_VALUE, 8'h11, 4'd0, 1'b1, 8'h00, 4'd0);
        // build 10 15 20 30 40 50
        add_entry(OP_INSERT_INDEX, 8'h20, 4'd0, 1'b0, 8'h00, 4'd1);
        add_entry(OP_INSERT_INDEX, 8'h40, 4'd1, 1'b0, 8'h00, 4'd2);
        add_entry(OP_INSERT_INDEX, 8'h10, 4'd0, 1'b0, 8'h00, 4'd3);
        add_entry(OP_INSERT_INDEX, 8'h30, 4'd2, 1'b0, 8'h00, 4'd4);
        add_entry(OP_INSERT_INDEX, 8'h50, 4'd9, 1'b0, 8'h00, 4'd5);
        add_entry(OP_INSERT_INDEX, 8'h15, 4'd1, 1'b0, 8'h00, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b0, 8'h10, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd1, 1'b0, 8'h15, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd2, 1'b0, 8'h20, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd3, 1'b0, 8'h30, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd4, 1'b0, 8'h40, 4'd6);
        add_entry(OP_READ_INDEX,   8'h00, 4'd5, 1'b0, 8'h50, 4'd6);
        // faulting read keeps the last data_out
        add_entry(OP_READ_INDEX,   8'h00, 4'd6, 1'b1, 8'h50, 4'd6);
        // head, middle, tail deletes leave 15 20 40
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd0, 1'b0, 8'h00, 4'd5);
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd2, 1'b0, 8'h00, 4'd4);
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd3, 1'b0, 8'h00, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b0, 8'h15, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd1, 1'b0, 8'h20, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd2, 1'b0, 8'h40, 4'd3);
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd3, 1'b1, 8'h00, 4'd3);
        // duplicate 20, only the first one goes
        add_entry(OP_INSERT_INDEX, 8'h20, 4'd3, 1'b0, 8'h00, 4'd4);
        add_entry(OP_DELETE_VALUE, 8'h20, 4'd0, 1'b0, 8'h00, 4'd3);
        add_entry(OP_DELETE_VALUE, 8'h77, 4'd0, 1'b1, 8'h00, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b0, 8'h15, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd1, 1'b0, 8'h40, 4'd3);
        add_entry(OP_READ_INDEX,   8'h00, 4'd2, 1'b0, 8'h20, 4'd3);
        // drain by value, tail then head then last
        add_entry(OP_DELETE_VALUE, 8'h20, 4'd0, 1'b0, 8'h00, 4'd2);
        add_entry(OP_DELETE_VALUE, 8'h15, 4'd0, 1'b0, 8'h00, 4'd1);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b0, 8'h40, 4'd1);
        add_entry(OP_DELETE_VALUE, 8'h40, 4'd0, 1'b0, 8'h00, 4'd0);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b1, 8'h40, 4'd0);
        // fill to 81 .. 88
        add_entry(OP_INSERT_INDEX, 8'h81, 4'd0, 1'b0, 8'h00, 4'd1);
        add_entry(OP_INSERT_INDEX, 8'h82, 4'd1, 1'b0, 8'h00, 4'd2);
        add_entry(OP_INSERT_INDEX, 8'h84, 4'd2, 1'b0, 8'h00, 4'd3);
        add_entry(OP_INSERT_INDEX, 8'h83, 4'd2, 1'b0, 8'h00, 4'd4);
        add_entry(OP_INSERT_INDEX, 8'h85, 4'd4, 1'b0, 8'h00, 4'd5);
        add_entry(OP_INSERT_INDEX, 8'h86, 4'd5, 1'b0, 8'h00, 4'd6);
        add_entry(OP_INSERT_INDEX, 8'h88, 4'd6, 1'b0, 8'h00, 4'd7);
        add_entry(OP_INSERT_INDEX, 8'h87, 4'd6, 1'b0, 8'h00, 4'd8);
        add_entry(OP_INSERT_INDEX, 8'h99, 4'd0, 1'b1, 8'h00, 4'd8);
        // codes outside the op set
        add_entry(3'd1,            8'h00, 4'd0, 1'b1, 8'h00, 4'd8);
        add_entry(3'd3,            8'h00, 4'd0, 1'b1, 8'h00, 4'd8);
        add_entry(3'd4,            8'h00, 4'd0, 1'b1, 8'h00, 4'd8);
        add_entry(3'd6,            8'h00, 4'd0, 1'b1, 8'h00, 4'd8);
        add_entry(OP_READ_INDEX,   8'h00, 4'd8, 1'b1, 8'h40, 4'd8);
        add_entry(OP_READ_INDEX,   8'h00, 4'd7, 1'b0, 8'h88, 4'd8);
        add_entry(OP_READ_INDEX,   8'h00, 4'd0, 1'b0, 8'h81, 4'd8);
        add_entry(OP_DELETE_INDEX, 8'h00, 4'd4, 1'b0, 8'h00, 4'd7);
        add_entry(OP_READ_INDEX,   8'h00, 4'd4, 1'b0, 8'h86, 4'd7);
        add_entry(OP_READ_INDEX,   8'h00, 4'd6, 1'b0, 8'h88, 4'd7);
    endtask

    // strobe op_start, then wait for op_done and check the status
    task automatic run_entry(input int idx);
        int   cycles;
        int   errors_before;
        logic exp_full;
        logic exp_empty;
        errors_before = error_count;
        cycles        = 0;
        exp_full      = (tab_len[idx] == addr_t'(MAX_NODE));
        exp_empty     = (tab_len[idx] == '0);
        @(negedge clk);
        op       = op_t'(tab_op[idx]);
        data_in  = tab_data[idx];
        index_in = tab_index[idx];
        op_start = 1'b1;
        @(negedge clk);
        op_start = 1'b0;
        while (op_done !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (op_done !== 1'b1) begin
            timed_out = 1'b1;
            $display("entry %0d: op_done never came within %0d cycles", idx, TIMEOUT_CYCLES);
        end else begin
            check_equal("fault", 32'(fault), 32'(tab_fault[idx]));
            if (tab_op[idx] == OP_READ_INDEX) begin
                check_equal("data_out", 32'(data_out), 32'(tab_dout[idx]));
            end
            check_equal("length", 32'(length), 32'(tab_len[idx]));
            check_equal("full", 32'(full), 32'(exp_full));
            check_equal("empty", 32'(empty), 32'(exp_empty));
        end
        entries_run++;
        if (timed_out || error_count != errors_before) begin
            entries_failed++;
            $display("entry %0d op %0d index %0d: failed", idx, tab_op[idx], tab_index[idx]);
        end else begin
            $display("entry %0d op %0d index %0d: ok", idx, tab_op[idx], tab_index[idx]);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        rst            = 1'b1;
        op             = OP_READ_INDEX;
        op_start       = 1'b0;
        data_in        = '0;
        index_in       = '0;
        error_count    = 0;
        entries_run    = 0;
        entries_failed = 0;
        timed_out      = 1'b0;
        build_table();

        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // idle status straight out of reset
        check_equal("op_done", 32'(op_done), 32'h0);
        check_equal("fault", 32'(fault), 32'h0);
        check_equal("length", 32'(length), 32'h0);
        check_equal("empty", 32'(empty), 32'h1);
        check_equal("full", 32'(full), 32'h0);
        check_equal("data_out", 32'(data_out), 32'h0);
        if (error_count == 0) begin
            $display("reset values: ok");
        end else begin
            $display("reset values: failed");
        end

        for (n = 0; n < tab_op.size() && !timed_out; n++) begin
            run_entry(n);
        end

        $display("entries run %0d of %0d, failed %0d, mismatches %0d",
                 entries_run, tab_op.size(), entries_failed, error_count);
        if (error_count == 0 && !timed_out && entries_run == tab_op.size()) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
    output logic clk
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

endmodule
